//--- rtl/cpu_stats_pkg.sv
`default_nettype none

package cpu_stats_pkg;

    // width of every performance counter
    localparam int STAT_W = 32;

    // which statistic a bcd conversion belongs to
    typedef enum logic [1:0] {
        STAT_CYCLES = 2'd0,
        STAT_UNCOND = 2'd1,
        STAT_COND   = 2'd2
    } stat_sel_e;

endpackage

`default_nettype wire

//--- rtl/disp_pkg.sv
`default_nettype none

package disp_pkg;

    localparam int DIGITS = 8;              // digits on the board
    localparam int SCAN_DIV_DEF = 50000;    // about 1 kHz per digit at 50 MHz

    // display opcode from the cpu, unlisted codes show zero
    typedef enum logic [2:0] {
        OP_PROGRAM = 3'b000,
        OP_CYCLES  = 3'b001,
        OP_RAM     = 3'b010,
        OP_UNCOND  = 3'b011,
        OP_COND    = 3'b111
    } disp_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // active low segment patterns, bit 7 is the dot and stays dark
    localparam logic [7:0] SEG_HEX [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0,     // 0 1 2 3
        8'h99, 8'h92, 8'h82, 8'hf8,     // 4 5 6 7
        8'h80, 8'h98, 8'h88, 8'h83,     // 8 9 a b
        8'ha7, 8'ha1, 8'h86, 8'h8e      // c d e f
    };

    // one cold anode select, entry k lights digit k
    localparam logic [DIGITS-1:0] AN_SEL [DIGITS] = '{
        8'hfe, 8'hfd, 8'hfb, 8'hf7,
        8'hef, 8'hdf, 8'hbf, 8'h7f
    };

endpackage

`default_nettype wire

//--- rtl/bcd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface bcd_if;
    import cpu_stats_pkg::*;

    logic              req_valid;   // one cycle, only with a credit held
    logic [STAT_W-1:0] req_bin;
    stat_sel_e         req_tag;
    logic              rsp_valid;
    logic [STAT_W-1:0] rsp_bcd;     // eight bcd digits, lsd in [3:0]
    stat_sel_e         rsp_tag;     // echo of req_tag
    logic              credit;      // returned together with rsp_valid

    modport requester (
        output req_valid, req_bin, req_tag,
        input  rsp_valid, rsp_bcd, rsp_tag, credit
    );

    modport converter (
        input  req_valid, req_bin, req_tag,
        output rsp_valid, rsp_bcd, rsp_tag, credit
    );

endinterface

`default_nettype wire

//--- rtl/perf_counters.sv
`timescale 1ns/100ps
`default_nettype none

module perf_counters (
    input  logic                             clk_p,
    input  logic                             rst_n,
    input  logic                             cycle_tick,
    input  logic                             uncond_branch,
    input  logic                             cond_branch,
    output logic [cpu_stats_pkg::STAT_W-1:0] cycle_count,
    output logic [cpu_stats_pkg::STAT_W-1:0] uncond_count,
    output logic [cpu_stats_pkg::STAT_W-1:0] cond_count
);

    // event pulses are single cycle, every counter wraps at 2^32
    always_ff @(posedge clk_p)
    begin
        if (!rst_n)
        begin
            cycle_count  <= '0;
            uncond_count <= '0;
            cond_count   <= '0;
        end
        else
        begin
            if (cycle_tick)
                cycle_count <= cycle_count + 1'b1;
            if (uncond_branch)
                uncond_count <= uncond_count + 1'b1;    // j / jal / jr
            if (cond_branch)
                cond_count <= cond_count + 1'b1;        // taken or not
        end
    end

endmodule

`default_nettype wire

//--- rtl/bcd_converter.sv
`timescale 1ns/100ps
`default_nettype none

module bcd_converter (
    input logic      clk_p,
    input logic      rst_n,
    bcd_if.converter bcd
);
    import cpu_stats_pkg::*;

    typedef enum logic {
        IDLE,
        SHIFT
    } state_e;

    state_e                    state;
    logic [$clog2(STAT_W)-1:0] bit_cnt;     // shift steps done
    logic                      done_q;
    logic [STAT_W-1:0]         bin_q;       // binary bits left, msb first
    logic [STAT_W-1:0]         bcd_q;       // eight packed bcd digits
    logic [STAT_W-1:0]         bcd_adj;
    stat_sel_e                 tag_q;

    ////////////////////////////////////////////////////////////////////////////
    // add 3 to every digit of 5 or more before the shift
    always_comb
    begin
        bcd_adj = bcd_q;
        for (int i = 0; i < STAT_W / 4; i++)
        begin
            if (bcd_q[4*i +: 4] >= 4'd5)
                bcd_adj[4*i +: 4] = bcd_q[4*i +: 4] + 4'd3;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // control FSM, one load cycle then 32 shift cycles
    always_ff @(posedge clk_p)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            bit_cnt <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (bcd.req_valid)
                    begin
                        bit_cnt <= '0;
                        state   <= SHIFT;
                    end
                end
                SHIFT:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == $bits(bit_cnt)'(STAT_W - 1))
                    begin
                        state  <= IDLE;
                        done_q <= 1'b1;     // result ready next cycle
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // carry out of the top digit is dropped, so the result is mod 10^8
    always_ff @(posedge clk_p)
    begin
        if (state == IDLE && bcd.req_valid)
        begin
            bin_q <= bcd.req_bin;
            bcd_q <= '0;
            tag_q <= bcd.req_tag;
        end
        else if (state == SHIFT)
        begin
            bin_q <= {bin_q[STAT_W-2:0], 1'b0};
            bcd_q <= {bcd_adj[STAT_W-2:0], bin_q[STAT_W-1]};
        end
    end

    assign bcd.rsp_valid = done_q;
    assign bcd.rsp_bcd   = bcd_q;
    assign bcd.rsp_tag   = tag_q;
    assign bcd.credit    = done_q;  // engine is free again

endmodule

`default_nettype wire

//--- rtl/display_source_mux.sv
`timescale 1ns/100ps
`default_nettype none

module display_source_mux (
    input  logic                              clk_p,
    input  logic                              rst_n,
    input  disp_pkg::disp_op_e                display_op,
    input  logic                              led_cpu_enable,   // syscall 34 strobe
    input  logic [4*disp_pkg::DIGITS-1:0]     led_data_in,
    input  logic [4*disp_pkg::DIGITS-1:0]     ram_data,
    input  logic [cpu_stats_pkg::STAT_W-1:0]  cycle_count,
    input  logic [cpu_stats_pkg::STAT_W-1:0]  uncond_count,
    input  logic [cpu_stats_pkg::STAT_W-1:0]  cond_count,
    bcd_if.requester                          bcd,
    output logic [4*disp_pkg::DIGITS-1:0]     disp_word
);
    import cpu_stats_pkg::*;
    import disp_pkg::*;

    logic              cnt_op;      // opcode shows a counter
    stat_sel_e         op_tag;
    logic [STAT_W-1:0] op_count;
    logic [1:0]        credit_cnt;
    logic              issue;

    ////////////////////////////////////////////////////////////////////////////
    // opcode decode
    always_comb
    begin
        cnt_op   = 1'b0;
        op_tag   = STAT_CYCLES;
        op_count = cycle_count;
        case (display_op)
            OP_CYCLES:
            begin
                cnt_op = 1'b1;
            end
            OP_UNCOND:
            begin
                cnt_op   = 1'b1;
                op_tag   = STAT_UNCOND;
                op_count = uncond_count;
            end
            OP_COND:
            begin
                cnt_op   = 1'b1;
                op_tag   = STAT_COND;
                op_count = cond_count;
            end
            default:
            begin
                cnt_op = 1'b0;
            end
        endcase
    end

    // a credit arriving this cycle may be spent at once
    assign issue = cnt_op && ((credit_cnt != 2'd0) || bcd.credit);

    ////////////////////////////////////////////////////////////////////////////
    // conversion requests
    always_ff @(posedge clk_p)
    begin
        if (!rst_n)
        begin
            credit_cnt    <= 2'd1;
            bcd.req_valid <= 1'b0;
        end
        else
        begin
            bcd.req_valid <= issue;
            credit_cnt    <= credit_cnt + {1'b0, bcd.credit} - {1'b0, issue};
        end
    end

    always_ff @(posedge clk_p)
    begin
        if (issue)
        begin
            bcd.req_bin <= op_count;
            bcd.req_tag <= op_tag;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // display word
    always_ff @(posedge clk_p)
    begin
        if (!rst_n)
            disp_word <= '0;
        else
        begin
            case (display_op)
                OP_PROGRAM:
                begin
                    if (led_cpu_enable)
                        disp_word <= led_data_in;   // hold between strobes
                end
                OP_RAM: disp_word <= ram_data;
                OP_CYCLES, OP_UNCOND, OP_COND:
                begin
                    // stale tag after an opcode switch is dropped
                    if (bcd.rsp_valid && bcd.rsp_tag == op_tag)
                        disp_word <= bcd.rsp_bcd;
                end
                default: disp_word <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/seg_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module seg_scanner #(
    parameter int scan_div = disp_pkg::SCAN_DIV_DEF
) (
    input  logic                          clk_p,
    input  logic                          rst_n,
    input  logic [4*disp_pkg::DIGITS-1:0] disp_word,
    output logic [7:0]                    seg,
    output logic [disp_pkg::DIGITS-1:0]   an
);
    import disp_pkg::*;

    logic [$clog2(scan_div+1)-1:0] pre_cnt;     // clocks within one digit
    logic                          scan_tick;
    logic [$clog2(DIGITS)-1:0]     digit_idx;
    logic [$clog2(DIGITS)-1:0]     next_idx;
    logic [3:0]                    nibble;

    ////////////////////////////////////////////////////////////////////////////
    // prescaler
    assign scan_tick = (pre_cnt == $bits(pre_cnt)'(scan_div - 1));

    always_ff @(posedge clk_p)
    begin
        if (!rst_n)
            pre_cnt <= '0;
        else if (scan_tick)
            pre_cnt <= '0;
        else
            pre_cnt <= pre_cnt + 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // digit rotation and decode
    assign next_idx = (digit_idx == $bits(digit_idx)'(DIGITS - 1)) ? '0
                                                                     : digit_idx + 1'b1;
    assign nibble   = disp_word[4*next_idx +: 4];   // digit k shows nibble k

    always_ff @(posedge clk_p)
    begin
        if (!rst_n)
        begin
            // parked on the last digit so the first tick lights digit 0
            digit_idx <= $bits(digit_idx)'(DIGITS - 1);
            seg       <= '1;    // dark until the first tick
            an        <= '1;
        end
        else if (scan_tick)
        begin
            digit_idx <= next_idx;
            seg       <= SEG_HEX[nibble];
            an        <= AN_SEL[next_idx];
        end
    end

endmodule

`default_nettype wire

//--- rtl/led_display_top.sv
`timescale 1ns/100ps
`default_nettype none

module led_display_top #(
    parameter int scan_div = disp_pkg::SCAN_DIV_DEF
) (
    input  logic        clk_p,
    input  logic        rst_n,
    input  logic [2:0]  display_op,
    input  logic        led_cpu_enable,
    input  logic [31:0] led_data_in,
    input  logic [31:0] ram_data,
    input  logic        cycle_tick,
    input  logic        uncond_branch,
    input  logic        cond_branch,
    output logic [7:0]  seg,
    output logic [7:0]  an
);
    import cpu_stats_pkg::*;
    import disp_pkg::*;

    logic [STAT_W-1:0]     cycle_count;
    logic [STAT_W-1:0]     uncond_count;
    logic [STAT_W-1:0]     cond_count;
    logic [4*DIGITS-1:0]   disp_word;

    bcd_if bcd0 ();     // selector to converter link

    perf_counters u_counters (
        .clk_p         (clk_p),
        .rst_n         (rst_n),
        .cycle_tick    (cycle_tick),
        .uncond_branch (uncond_branch),
        .cond_branch   (cond_branch),
        .cycle_count   (cycle_count),
        .uncond_count  (uncond_count),
        .cond_count    (cond_count)
    );

    display_source_mux u_mux (
        .clk_p          (clk_p),
        .rst_n          (rst_n),
        .display_op     (disp_op_e'(display_op)),   // raw code, unused ones show 0
        .led_cpu_enable (led_cpu_enable),
        .led_data_in    (led_data_in),
        .ram_data       (ram_data),
        .cycle_count    (cycle_count),
        .uncond_count   (uncond_count),
        .cond_count     (cond_count),
        .bcd            (bcd0.requester),
        .disp_word      (disp_word)
    );

    bcd_converter u_bcd (
        .clk_p (clk_p),
        .rst_n (rst_n),
        .bcd   (bcd0.converter)
    );

    seg_scanner #(
        .scan_div (scan_div)
    ) u_scan (
        .clk_p     (clk_p),
        .rst_n     (rst_n),
        .disp_word (disp_word),
        .seg       (seg),
        .an        (an)
    );

endmodule

`default_nettype wire

//--- tests/tb_led_display.sv
`timescale 1ns/100ps
`default_nettype none

module tb_led_display;
    import cpu_stats_pkg::*;
    import disp_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYC     = 16;
    localparam int SCAN_DIV    = 4;
    localparam int FRAME_CYC   = DIGITS * SCAN_DIV;         // 32 clocks per frame
    localparam int CONV_CYC    = 68;                        // two conversions
    localparam int CAPTURE_CYC = 2 * FRAME_CYC + SCAN_DIV;
    localparam int MAX_EVENTS  = 1023;                      // 10 random bits
    localparam int SETTLE_CYC  = CONV_CYC + FRAME_CYC + CAPTURE_CYC;
    localparam int WATCHDOG_CYC =
        RST_CYC + 3 * FRAME_CYC                             // anode walk
        + 5 * (8 + CAPTURE_CYC)                             // program, ram, unused
        + MAX_EVENTS + SETTLE_CYC                           // cycle count
        + 5 * MAX_EVENTS + 3 * SETTLE_CYC + 40              // branch counts
        + RST_CYC + 2 * MAX_EVENTS + SETTLE_CYC;            // long tick run

    logic                clk_p;
    logic                rst_n;
    logic [2:0]          display_op;
    logic                led_cpu_enable;
    logic [31:0]         led_data_in;
    logic [31:0]         ram_data;
    logic                cycle_tick;
    logic                uncond_branch;
    logic                cond_branch;
    logic [7:0]          seg;
    logic [DIGITS-1:0]   an;

    logic [31:0]         lfsr;
    int                  word_errs;
    int                  an_errs;
    int                  other_errs;
    int                  exp_cycles;
    int                  exp_uncond;
    int                  exp_cond;

    led_display_top #(
        .scan_div (SCAN_DIV)
    ) dut0 (
        .clk_p          (clk_p),
        .rst_n          (rst_n),
        .display_op     (display_op),
        .led_cpu_enable (led_cpu_enable),
        .led_data_in    (led_data_in),
        .ram_data       (ram_data),
        .cycle_tick     (cycle_tick),
        .uncond_branch  (uncond_branch),
        .cond_branch    (cond_branch),
        .seg            (seg),
        .an             (an)
    );

    initial
    begin
        clk_p = 1'b0;
        forever #(CLK_PERIOD / 2) clk_p = ~clk_p;
    end

    initial
    begin
        #(WATCHDOG_CYC * CLK_PERIOD * 2);
        $display("watchdog: run passed %0d ns without finishing the tests",
                 WATCHDOG_CYC * CLK_PERIOD * 2);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // one event on each of n clocks
    task automatic drive_events(input stat_sel_e which, input int n);
        if (n == 0)
            return;
        case (which)
            STAT_CYCLES: cycle_tick    = 1'b1;
            STAT_UNCOND: uncond_branch = 1'b1;
            default:     cond_branch   = 1'b1;
        endcase
        repeat (n) @(negedge clk_p);
        cycle_tick    = 1'b0;
        uncond_branch = 1'b0;
        cond_branch   = 1'b0;
    endtask

    // expected decimal digits of n mod 10^8
    function automatic logic [4*DIGITS-1:0] dec_word(input longint n);
        logic [4*DIGITS-1:0] w;
        longint              v;
        v = n % 64'd100000000;
        for (int i = 0; i < DIGITS; i++)
        begin
            w[4*i +: 4] = 4'(v % 10);
            v           = v / 10;
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // frame capture and compare
    task automatic capture_frame(output logic [4*DIGITS-1:0] word);
        logic [7:0] pat;
        bit         found;
        word = '0;
        while (an == AN_SEL[0])     // start on a fresh digit 0
            @(negedge clk_p);
        while (an != AN_SEL[0])
            @(negedge clk_p);
        for (int k = 0; k < DIGITS; k++)
        begin
            while (an != AN_SEL[k])
                @(negedge clk_p);
            pat   = seg;
            found = 1'b0;
            for (int i = 0; i < 16; i++)
            begin
                if (SEG_HEX[i] == pat)
                begin
                    word[4*k +: 4] = 4'(i);
                    found          = 1'b1;
                end
            end
            if (!found)
            begin
                other_errs++;
                $display("digit %0d showed segment pattern %02h, which is no hex digit",
                         k, pat);
            end
        end
    endtask

    task automatic check_word(input logic [4*DIGITS-1:0] got,
                              input logic [4*DIGITS-1:0] exp, input string what);
        if (got !== exp)
        begin
            word_errs++;
            $display("error at %0t ns: %s shows %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_an(input logic [DIGITS-1:0] got, input logic [DIGITS-1:0] exp,
                            input string what);
        if (got !== exp)
        begin
            an_errs++;
            $display("error at %0t ns: %s anode %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_seg(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
        begin
            word_errs++;
            $display("error at %0t ns: %s segments %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    task automatic reset_and_scan();
        logic [DIGITS-1:0] prev;
        check_an(an, '1, "before first tick");      // dark display
        check_seg(seg, '1, "before first tick");
        for (int k = 0; k < 2 * DIGITS; k++)
        begin
            prev = an;
            do
                @(negedge clk_p);
            while (an == prev);
            check_an(an, AN_SEL[k % DIGITS], "scan step");
        end
    endtask

    task automatic program_value();
        logic [31:0]         v1;
        logic [31:0]         v2;
        logic [4*DIGITS-1:0] got;
        rand_bits(32, v1);
        rand_bits(32, v2);
        display_op     = OP_PROGRAM;
        led_data_in    = v1;
        led_cpu_enable = 1'b1;
        @(negedge clk_p);
        led_cpu_enable = 1'b0;
        led_data_in    = v2;        // presented without a strobe
        repeat (4) @(negedge clk_p);
        capture_frame(got);
        check_word(got, v1, "program value");
    endtask

    task automatic ram_and_unused();
        logic [31:0]         v;
        logic [4*DIGITS-1:0] got;
        rand_bits(32, v);
        ram_data   = v;
        display_op = OP_RAM;
        repeat (4) @(negedge clk_p);
        capture_frame(got);
        check_word(got, v, "ram word");
        display_op = 3'b100;
        repeat (4) @(negedge clk_p);
        capture_frame(got);
        check_word(got, '0, "unused opcode 100");
        display_op = OP_RAM;        // ram word on the display again
        repeat (2) @(negedge clk_p);
        display_op = 3'b110;
        repeat (4) @(negedge clk_p);
        capture_frame(got);
        check_word(got, '0, "unused opcode 110");
    endtask

    task automatic cycle_count_shown();
        logic [31:0]         n;
        logic [4*DIGITS-1:0] got;
        rand_bits(10, n);
        drive_events(STAT_CYCLES, int'(n));
        exp_cycles += int'(n);
        display_op = OP_CYCLES;
        repeat (CONV_CYC + FRAME_CYC) @(negedge clk_p);
        capture_frame(got);
        check_word(got, dec_word(exp_cycles), "cycle count");
    endtask

    task automatic branch_counts_shown();
        logic [31:0]         n;
        logic [4*DIGITS-1:0] got;
        rand_bits(10, n);
        drive_events(STAT_UNCOND, int'(n));
        exp_uncond += int'(n);
        rand_bits(10, n);
        if (exp_cond + int'(n) == exp_uncond)
            n = n + 32'd1;          // keep the two branch counts apart
        drive_events(STAT_COND, int'(n));
        exp_cond += int'(n);
        display_op = OP_UNCOND;
        repeat (CONV_CYC + FRAME_CYC) @(negedge clk_p);
        capture_frame(got);
        check_word(got, dec_word(exp_uncond), "unconditional branches");
        rand_bits(10, n);
        drive_events(STAT_CYCLES, int'(n));     // other counters stay put
        exp_cycles += int'(n);
        display_op = OP_COND;
        repeat (CONV_CYC + FRAME_CYC) @(negedge clk_p);
        capture_frame(got);
        check_word(got, dec_word(exp_cond), "conditional branches");
        // switch while conversions are in flight
        display_op = OP_CYCLES;
        repeat (3) @(negedge clk_p);
        display_op = OP_COND;
        repeat (5) @(negedge clk_p);
        display_op = OP_CYCLES;
        repeat (20) @(negedge clk_p);
        display_op = OP_UNCOND;
        repeat (CONV_CYC + FRAME_CYC) @(negedge clk_p);
        capture_frame(got);
        check_word(got, dec_word(exp_uncond), "last selected counter");
    endtask

    // ticks every clock straight out of reset
    task automatic long_tick_run();
        logic [31:0]         k;
        logic [4*DIGITS-1:0] got;
        rand_bits(10, k);
        k          = k + 32'd1000;
        rst_n      = 1'b0;
        display_op = OP_PROGRAM;
        cycle_tick = 1'b1;
        repeat (RST_CYC) @(negedge clk_p);
        rst_n = 1'b1;
        repeat (int'(k)) @(negedge clk_p);
        cycle_tick = 1'b0;
        exp_cycles = int'(k);
        exp_uncond = 0;
        exp_cond   = 0;
        display_op = OP_CYCLES;
        repeat (CONV_CYC + FRAME_CYC) @(negedge clk_p);
        capture_frame(got);
        check_word(got, dec_word(exp_cycles), "cycle count after long run");
    endtask

    initial
    begin
        rst_n          = 1'b0;
        display_op     = OP_PROGRAM;
        led_cpu_enable = 1'b0;
        led_data_in    = '0;
        ram_data       = '0;
        cycle_tick     = 1'b0;
        uncond_branch  = 1'b0;
        cond_branch    = 1'b0;
        lfsr           = 32'hf191193a;
        word_errs      = 0;
        an_errs        = 0;
        other_errs     = 0;
        exp_cycles     = 0;
        exp_uncond     = 0;
        exp_cond       = 0;
        repeat (RST_CYC) @(negedge clk_p);
        rst_n = 1'b1;
        reset_and_scan();
        program_value();
        ram_and_unused();
        cycle_count_shown();
        branch_counts_shown();
        long_tick_run();
        $display("errors: %0d display word, %0d anode, %0d other",
                 word_errs, an_errs, other_errs);
        if (word_errs + an_errs + other_errs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/cpu_stats_pkg.sv
rtl/disp_pkg.sv
rtl/bcd_if.sv
rtl/perf_counters.sv
rtl/bcd_converter.sv
rtl/display_source_mux.sv
rtl/seg_scanner.sv
rtl/led_display_top.sv
tests/tb_led_display.sv

//--- Bender.yml
package:
  name: led_display

sources:
  - rtl/cpu_stats_pkg.sv
  - rtl/disp_pkg.sv
  - rtl/bcd_if.sv
  - rtl/perf_counters.sv
  - rtl/bcd_converter.sv
  - rtl/display_source_mux.sv
  - rtl/seg_scanner.sv
  - rtl/led_display_top.sv
  - target: test
    files:
      - tests/tb_led_display.sv
